/* axis_data_to_chdr.f */
hdl/chdr_pkg.sv
hdl/data_stream_pkg.sv
hdl/sync_fifo.sv
hdl/pkt_info_capture.sv
hdl/payload_buffer.sv
hdl/chdr_framer.sv
hdl/axis_data_to_chdr.sv
dv/axis_data_to_chdr_sva.sv
dv/tb_axis_data_to_chdr.sv

/* dv/axis_data_to_chdr_sva.sv */
`default_nettype none

// Valid/ready stream rules, one instance per stream
module axis_data_to_chdr_sva #(
  parameter int WIDTH = 8
) (
  input wire logic             axis_data_clk,
  input wire logic             axis_data_rst,
  input wire logic [WIDTH-1:0] i_data,
  input wire logic             i_valid,
  input wire logic             i_ready
);

  // Stalled beat keeps valid up
  a_valid_held : assert property (@(posedge axis_data_clk) disable iff (axis_data_rst)
    i_valid && !i_ready |=> i_valid)
    else $error("valid dropped while the beat was stalled");

  // Stalled beat keeps its data
  a_data_held : assert property (@(posedge axis_data_clk) disable iff (axis_data_rst)
    i_valid && !i_ready |=> $stable(i_data))
    else $error("data changed while the beat was stalled");

endmodule

// CHDR output of the framer
bind chdr_framer axis_data_to_chdr_sva #(
  .WIDTH ($bits(chdr_pkg::chdr_beat_t))
) u_out_sva (
  .axis_data_clk (axis_data_clk),
  .axis_data_rst (axis_data_rst),
  .i_data        (o_chdr_beat),
  .i_valid       (o_chdr_tvalid),
  .i_ready       (i_chdr_tready)
);

// Input side, stalled by the gating register or a full payload FIFO
bind payload_buffer axis_data_to_chdr_sva #(
  .WIDTH ($bits(data_stream_pkg::data_beat_t))
) u_in_sva (
  .axis_data_clk (axis_data_clk),
  .axis_data_rst (axis_data_rst),
  .i_data        (i_s_beat),
  .i_valid       (i_s_tvalid),
  .i_ready       (o_s_tready)
);

`default_nettype wire

/* dv/tb_axis_data_to_chdr.sv */
`default_nettype none

module tb_axis_data_to_chdr
  import data_stream_pkg::*;
  import chdr_pkg::*;
();

  localparam int NUM_ROWS       = 9;
  localparam int TIMEOUT_CYCLES = 200 * NUM_ROWS;
  // Cycles of a stalled input before the sink is let go again
  localparam int STALL_LIMIT    = 8;

  // One table row per packet
  typedef struct packed {
    logic [3:0] num_beats;
    logic [1:0] last_keep;
    sideband_t  sb;
    logic [6:0] duty;
    logic       hold_out;
  } pkt_row_t;

  logic       axis_data_clk = 1'b0;
  logic       axis_data_rst;
  data_beat_t i_s_beat;
  sideband_t  i_s_sideband;
  logic       i_s_tvalid;
  logic       o_s_tready;
  chdr_beat_t o_chdr_beat;
  logic       o_chdr_tvalid;
  logic       i_chdr_tready;

  pkt_row_t   rows [NUM_ROWS];
  chdr_beat_t exp_q [$];
  bit         exp_hdr_q [$];
  int         cycle_count  = 0;
  int         stall_count  = 0;
  int         cur_duty     = 100;
  bit         block_req    = 1'b0;
  bit         gating_seen  = 1'b0;
  bit         verdict_done = 1'b0;

  axis_data_to_chdr UUT (
    .axis_data_clk (axis_data_clk),
    .axis_data_rst (axis_data_rst),
    .i_s_beat      (i_s_beat),
    .i_s_sideband  (i_s_sideband),
    .i_s_tvalid    (i_s_tvalid),
    .o_s_tready    (o_s_tready),
    .o_chdr_beat   (o_chdr_beat),
    .o_chdr_tvalid (o_chdr_tvalid),
    .i_chdr_tready (i_chdr_tready)
  );

  always #20 axis_data_clk = ~axis_data_clk;

  // --------------------
  // Checks
  // --------------------

  task automatic end_in_failure();
    verdict_done = 1'b1;
    $display("Test failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_header(input chdr_header_t got, input chdr_header_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: header %h seq %0d len %0d, expected %h seq %0d len %0d",
               $time, got, got.seq_num, got.length, exp, exp.seq_num, exp.length);
      end_in_failure();
    end
  endtask

  task automatic check_word(input chdr_beat_t got, input chdr_beat_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: word %h tlast %0b, expected %h tlast %0b",
               $time, got.tdata.raw, got.tlast, exp.tdata.raw, exp.tlast);
      end_in_failure();
    end
  endtask

  // --------------------
  // Stimulus helpers
  // --------------------

  function automatic pkt_row_t make_row(int beats, logic [1:0] keep, logic [63:0] ts,
                                        logic has_time, logic eov, logic eob,
                                        int duty, logic hold);
    pkt_row_t row;
    row.num_beats    = 4'(beats);
    row.last_keep    = keep;
    row.sb.timestamp = ts;
    row.sb.has_time  = has_time;
    row.sb.eov       = eov;
    row.sb.eob       = eob;
    row.duty         = 7'(duty);
    row.hold_out     = hold;
    return row;
  endfunction

  // Header and optional timestamp word, built from the framing rules
  task automatic expect_header(input pkt_row_t row, input logic [15:0] seq);
    chdr_beat_t word;
    int         n_items;
    n_items = 2 * (int'(row.num_beats) - 1) + int'(row.last_keep[0]) + int'(row.last_keep[1]);
    word = '0;
    word.tdata.hdr.eob      = row.sb.eob;
    word.tdata.hdr.eov      = row.sb.eov;
    // Type 7 is data with time, 6 plain data
    word.tdata.hdr.pkt_type = row.sb.has_time ? 3'd7 : 3'd6;
    word.tdata.hdr.seq_num  = seq;
    word.tdata.hdr.length   = 16'(8 + (row.sb.has_time ? 8 : 0) + 4 * n_items);
    exp_q.push_back(word);
    exp_hdr_q.push_back(1'b1);
    if (row.sb.has_time) begin
      word = '0;
      word.tdata.raw = row.sb.timestamp;
      exp_q.push_back(word);
      exp_hdr_q.push_back(1'b0);
    end
  endtask

  // Hold the beat until the DUT takes it
  task automatic send_beat(input data_beat_t beat, input sideband_t sb);
    bit taken;
    i_s_beat     = beat;
    i_s_sideband = sb;
    i_s_tvalid   = 1'b1;
    taken        = 1'b0;
    while (!taken) begin
      @(negedge axis_data_clk);
      taken = o_s_tready;
      @(posedge axis_data_clk);
      #5;
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    data_beat_t  beat;
    sideband_t   sb;
    chdr_beat_t  word;
    logic [15:0] seq;
    void'($urandom(32'h7fb80812));
    axis_data_rst = 1'b1;
    i_s_beat      = '0;
    i_s_sideband  = '0;
    i_s_tvalid    = 1'b0;
    seq           = '0;
    // Beats, last keep, timestamp, has_time, eov, eob, ready duty, hold output
    rows[0] = make_row(4, 2'b11, 64'h0000_0012_3456_7000, 1'b1, 1'b0, 1'b0, 100, 1'b0);
    rows[1] = make_row(1, 2'b01, 64'h0, 1'b0, 1'b0, 1'b0, 100, 1'b0);
    rows[2] = make_row(7, 2'b11, 64'h0000_0000_dead_0100, 1'b1, 1'b1, 1'b0, 50, 1'b0);
    rows[3] = make_row(3, 2'b01, 64'h0, 1'b0, 1'b0, 1'b1, 30, 1'b0);
    // Burst of short packets with the sink stalled
    rows[4] = make_row(1, 2'b11, 64'h0000_0000_dead_0200, 1'b1, 1'b0, 1'b0, 100, 1'b1);
    rows[5] = make_row(1, 2'b01, 64'h0, 1'b0, 1'b1, 1'b0, 100, 1'b1);
    rows[6] = make_row(2, 2'b11, 64'h0000_0000_dead_0300, 1'b1, 1'b0, 1'b0, 100, 1'b1);
    rows[7] = make_row(1, 2'b11, 64'h0, 1'b0, 1'b0, 1'b1, 100, 1'b1);
    rows[8] = make_row(5, 2'b10, 64'h0000_0000_dead_0400, 1'b1, 1'b1, 1'b1, 70, 1'b0);
    repeat (10) @(posedge axis_data_clk);
    #5;
    axis_data_rst = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      cur_duty = int'(rows[r].duty);
      if (rows[r].hold_out) block_req = 1'b1;
      expect_header(rows[r], seq);
      seq = seq + 16'd1;
      for (int b = 0; b < int'(rows[r].num_beats); b++) begin
        beat.tdata = {$urandom, $urandom};
        beat.tlast = (b == int'(rows[r].num_beats) - 1);
        beat.tkeep = beat.tlast ? rows[r].last_keep : 2'b11;
        // Junk sideband on earlier beats, only the last one counts
        sb = beat.tlast ? rows[r].sb : sideband_t'({$urandom, $urandom, 3'($urandom)});
        word = '0;
        word.tdata.raw = beat.tdata;
        word.tlast     = beat.tlast;
        exp_q.push_back(word);
        exp_hdr_q.push_back(1'b0);
        send_beat(beat, sb);
      end
    end
    i_s_tvalid = 1'b0;
    // Drain, then leave time for stray words
    // The sink stays blocked until the input is held off, so draining needs the gating
    while (exp_q.size() != 0) @(posedge axis_data_clk);
    repeat (20) @(posedge axis_data_clk);
    verdict_done = 1'b1;
    $display("Test completed successfully");
    $finish;
  end

  // Sink ready, random per duty or held low during the burst
  initial begin
    i_chdr_tready = 1'b0;
    forever begin
      @(posedge axis_data_clk);
      #5;
      if (block_req && !gating_seen) i_chdr_tready = 1'b0;
      else i_chdr_tready = (($urandom % 100) < cur_duty);
    end
  end

  // --------------------
  // Output monitor
  // --------------------

  // Sampled mid-cycle, a transfer lands on the next rising edge
  always @(negedge axis_data_clk) begin
    if (!axis_data_rst) begin
      if (block_req && !gating_seen) begin
        if (i_s_tvalid && !o_s_tready) stall_count++;
        else stall_count = 0;
        if (stall_count >= STALL_LIMIT) gating_seen = 1'b1;
      end
      if (o_chdr_tvalid && i_chdr_tready) begin
        if (exp_q.size() == 0) begin
          $display("Output word %h arrived when no word was expected", o_chdr_beat);
          end_in_failure();
        end else begin
          if (exp_hdr_q[0]) check_header(o_chdr_beat.tdata.hdr, exp_q[0].tdata.hdr);
          check_word(o_chdr_beat, exp_q[0]);
          void'(exp_q.pop_front());
          void'(exp_hdr_q.pop_front());
        end
      end
    end
  end

  always @(posedge axis_data_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d words still expected", cycle_count, exp_q.size());
      end_in_failure();
    end
  end

  // Run stopped by an assertion
  final begin
    if (!verdict_done) $display("Test failed");
  end

endmodule

`default_nettype wire

/* hdl/axis_data_to_chdr.sv */
`default_nettype none

module axis_data_to_chdr
  import data_stream_pkg::*;
  import chdr_pkg::*;
(
  input  wire logic       axis_data_clk,
  input  wire logic       axis_data_rst,
  // Payload stream in, sideband valid on the last beat
  input  wire data_beat_t i_s_beat,
  input  wire sideband_t  i_s_sideband,
  input  wire logic       i_s_tvalid,
  output logic            o_s_tready,
  // CHDR stream out
  output chdr_beat_t      o_chdr_beat,
  output logic            o_chdr_tvalid,
  input  wire logic       i_chdr_tready
);

  logic       beat_accept;
  logic       info_space;
  pkt_info_t  info;
  logic       info_valid;
  logic       info_ready;
  data_beat_t pyld;
  logic       pyld_valid;
  logic       pyld_ready;

  // Length and sideband per packet
  pkt_info_capture u_info_capture (
    .axis_data_clk (axis_data_clk),
    .axis_data_rst (axis_data_rst),
    .i_s_beat      (i_s_beat),
    .i_s_sideband  (i_s_sideband),
    .i_beat_accept (beat_accept),
    .o_info_space  (info_space),
    .o_info        (info),
    .o_info_valid  (info_valid),
    .i_info_ready  (info_ready)
  );

  // Payload beats, side by side with the info queue
  payload_buffer u_payload_buffer (
    .axis_data_clk (axis_data_clk),
    .axis_data_rst (axis_data_rst),
    .i_s_beat      (i_s_beat),
    .i_s_tvalid    (i_s_tvalid),
    .o_s_tready    (o_s_tready),
    .o_beat_accept (beat_accept),
    .i_info_space  (info_space),
    .o_pyld        (pyld),
    .o_pyld_valid  (pyld_valid),
    .i_pyld_ready  (pyld_ready)
  );

  chdr_framer u_framer (
    .axis_data_clk (axis_data_clk),
    .axis_data_rst (axis_data_rst),
    .i_info        (info),
    .i_info_valid  (info_valid),
    .o_info_ready  (info_ready),
    .i_pyld        (pyld),
    .i_pyld_valid  (pyld_valid),
    .o_pyld_ready  (pyld_ready),
    .o_chdr_beat   (o_chdr_beat),
    .o_chdr_tvalid (o_chdr_tvalid),
    .i_chdr_tready (i_chdr_tready)
  );

endmodule

`default_nettype wire

/* hdl/chdr_framer.sv */
`default_nettype none

module chdr_framer
  import data_stream_pkg::*;
  import chdr_pkg::*;
(
  input  wire logic       axis_data_clk,
  input  wire logic       axis_data_rst,
  // Packet info queue
  input  wire pkt_info_t  i_info,
  input  wire logic       i_info_valid,
  output logic            o_info_ready,
  // Payload queue
  input  wire data_beat_t i_pyld,
  input  wire logic       i_pyld_valid,
  output logic            o_pyld_ready,
  // CHDR out
  output chdr_beat_t      o_chdr_beat,
  output logic            o_chdr_tvalid,
  input  wire logic       i_chdr_tready
);

  logic [1:0]   state;
  logic [15:0]  seq_num;
  logic [63:0]  ts_word;
  chdr_header_t hdr_fields;
  logic         hdr_xfer;

  // Header goes out when info is there and the sink takes it
  assign hdr_xfer = (state == FRM_ST_HDR) && i_info_valid && i_chdr_tready;

  // --------------------
  // Header fields
  // --------------------

  always_comb begin
    hdr_fields          = '0;
    hdr_fields.eob      = i_info.eob;
    hdr_fields.eov      = i_info.eov;
    hdr_fields.pkt_type = i_info.has_time ? CHDR_PKT_TYPE_DATA_TS : CHDR_PKT_TYPE_DATA;
    hdr_fields.seq_num  = seq_num;
    // Info length already counts the header
    hdr_fields.length   = i_info.length + (i_info.has_time ? 16'(CHDR_TS_BYTES) : 16'd0);
  end

  // --------------------
  // State machine
  // --------------------

  always_ff @(posedge axis_data_clk) begin
    if (axis_data_rst) begin
      state   <= FRM_ST_HDR;
      seq_num <= '0;
    end else begin
      case (state)
        FRM_ST_HDR: begin
          if (hdr_xfer) begin
            seq_num <= seq_num + 1'b1;
            state   <= i_info.has_time ? FRM_ST_TS : FRM_ST_PYLD;
          end
        end
        FRM_ST_TS: begin
          if (i_chdr_tready) state <= FRM_ST_PYLD;
        end
        FRM_ST_PYLD: begin
          // Back to header after the packet's last word
          if (i_pyld_valid && i_chdr_tready && i_pyld.tlast) state <= FRM_ST_HDR;
        end
        default: state <= FRM_ST_HDR;
      endcase
    end
  end

  // Timestamp held for the word after the header
  always_ff @(posedge axis_data_clk) begin
    if (hdr_xfer) ts_word <= i_info.timestamp;
  end

  // --------------------
  // Output mux
  // --------------------

  always_comb begin
    o_chdr_beat   = '0;
    o_chdr_tvalid = 1'b0;
    o_info_ready  = 1'b0;
    o_pyld_ready  = 1'b0;
    case (state)
      FRM_ST_HDR: begin
        o_chdr_beat.tdata.hdr = hdr_fields;
        o_chdr_tvalid         = i_info_valid;
        // Info entry leaves the queue with its header
        o_info_ready          = i_chdr_tready;
      end
      FRM_ST_TS: begin
        o_chdr_beat.tdata.raw = ts_word;
        o_chdr_tvalid         = 1'b1;
      end
      FRM_ST_PYLD: begin
        o_chdr_beat.tdata.raw = i_pyld.tdata;
        o_chdr_beat.tlast     = i_pyld.tlast;
        o_chdr_tvalid         = i_pyld_valid;
        o_pyld_ready          = i_chdr_tready;
      end
      default: begin
        o_chdr_tvalid = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/chdr_pkg.sv */
`default_nettype none

package chdr_pkg;

  // --------------------
  // Word format
  // --------------------

  // 64-bit CHDR bus, timestamp travels in its own word
  localparam int CHDR_W         = 64;
  localparam int CHDR_HDR_BYTES = 8;
  localparam int CHDR_TS_BYTES  = 8;

  // Packet type codes
  localparam logic [2:0] CHDR_PKT_TYPE_DATA    = 3'd6;
  localparam logic [2:0] CHDR_PKT_TYPE_DATA_TS = 3'd7;

  // Framer output states
  localparam logic [1:0] FRM_ST_HDR  = 2'd0;
  localparam logic [1:0] FRM_ST_TS   = 2'd1;
  localparam logic [1:0] FRM_ST_PYLD = 2'd2;

  // --------------------
  // Header and beat types
  // --------------------

  // Header fields, high bits first
  typedef struct packed {
    logic [5:0]  vc;
    logic        eob;
    logic        eov;
    logic [2:0]  pkt_type;
    logic [4:0]  num_mdata;
    logic [15:0] seq_num;
    logic [15:0] length;
    logic [15:0] dst_epid;
  } chdr_header_t;

  // Same word seen as header fields or as plain data
  typedef union packed {
    chdr_header_t      hdr;
    logic [CHDR_W-1:0] raw;
  } chdr_word_u;

  // One output beat
  typedef struct packed {
    chdr_word_u tdata;
    logic       tlast;
  } chdr_beat_t;

endpackage

`default_nettype wire

/* hdl/data_stream_pkg.sv */
`default_nettype none

package data_stream_pkg;

  // --------------------
  // Stream geometry
  // --------------------

  // Two 32-bit items per beat
  localparam int ITEM_W     = 32;
  localparam int NIPC       = 2;
  localparam int ITEM_BYTES = 4;

  // Buffer sizes as log2
  localparam int MTU_LOG2       = 6;
  localparam int INFO_FIFO_LOG2 = 2;

  // --------------------
  // Stream types
  // --------------------

  // Payload beat with per-item keep
  typedef struct packed {
    logic [ITEM_W*NIPC-1:0] tdata;
    logic [NIPC-1:0]        tkeep;
    logic                   tlast;
  } data_beat_t;

  // Sideband, only meaningful on the last beat
  typedef struct packed {
    logic [63:0] timestamp;
    logic        has_time;
    logic        eov;
    logic        eob;
  } sideband_t;

  // One entry per packet, length includes the header
  typedef struct packed {
    logic        eob;
    logic        eov;
    logic        has_time;
    logic [63:0] timestamp;
    logic [15:0] length;
  } pkt_info_t;

endpackage

`default_nettype wire

/* hdl/payload_buffer.sv */
`default_nettype none

module payload_buffer
  import data_stream_pkg::*;
(
  input  wire logic       axis_data_clk,
  input  wire logic       axis_data_rst,
  // Input stream
  input  wire data_beat_t i_s_beat,
  input  wire logic       i_s_tvalid,
  output logic            o_s_tready,
  output logic            o_beat_accept,
  // Info queue has room
  input  wire logic       i_info_space,
  // Buffered payload out
  output data_beat_t      o_pyld,
  output logic            o_pyld_valid,
  input  wire logic       i_pyld_ready
);

  logic gating;
  logic fifo_in_valid;
  logic fifo_in_ready;

  // --------------------
  // Input gating
  // --------------------

  // Blocks transfers while the info queue cannot take another packet
  always_ff @(posedge axis_data_clk) begin
    if (axis_data_rst) begin
      gating <= 1'b0;
    end else if (gating) begin
      if (i_info_space) gating <= 1'b0;
    end else if (!i_info_space && (!i_s_tvalid || o_beat_accept)) begin
      // Only close when no beat is left waiting mid-handshake
      gating <= 1'b1;
    end
  end

  assign fifo_in_valid = i_s_tvalid && !gating;
  assign o_s_tready    = fifo_in_ready && !gating;
  assign o_beat_accept = i_s_tvalid && o_s_tready;

  // One MTU of payload, since the header needs the whole packet first
  sync_fifo #(
    .WIDTH       ($bits(data_beat_t)),
    .DEPTH_LOG2  (MTU_LOG2)
  ) u_pyld_fifo (
    .axis_data_clk (axis_data_clk),
    .axis_data_rst (axis_data_rst),
    .i_data        (i_s_beat),
    .i_valid       (fifo_in_valid),
    .o_ready       (fifo_in_ready),
    .o_data        (o_pyld),
    .o_valid       (o_pyld_valid),
    .i_ready_out   (i_pyld_ready)
  );

endmodule

`default_nettype wire

/* hdl/pkt_info_capture.sv */
`default_nettype none

module pkt_info_capture
  import data_stream_pkg::*;
  import chdr_pkg::*;
(
  input  wire logic       axis_data_clk,
  input  wire logic       axis_data_rst,
  // Input stream view
  input  wire data_beat_t i_s_beat,
  input  wire sideband_t  i_s_sideband,
  input  wire logic       i_beat_accept,
  // Queue status for input gating
  output logic            o_info_space,
  // Packet info out
  output pkt_info_t       o_info,
  output logic            o_info_valid,
  input  wire logic       i_info_ready
);

  logic [15:0]             length_count;
  logic [15:0]             beat_bytes;
  pkt_info_t               info_entry;
  logic                    info_push;
  logic                    fifo_ready;
  logic [INFO_FIFO_LOG2:0] info_count;
  logic [INFO_FIFO_LOG2:0] info_pending;

  // --------------------
  // Length count
  // --------------------

  // Bytes carried by this beat, one item per keep bit
  always_comb begin
    beat_bytes = '0;
    for (int i = 0; i < NIPC; i++) begin
      if (i_s_beat.tkeep[i]) beat_bytes = beat_bytes + 16'(ITEM_BYTES);
    end
  end

  always_ff @(posedge axis_data_clk) begin
    if (axis_data_rst) begin
      length_count <= 16'(CHDR_HDR_BYTES);
      info_push    <= 1'b0;
    end else begin
      info_push <= 1'b0;
      if (i_beat_accept) begin
        if (i_s_beat.tlast) begin
          // Restart at header size for the next packet
          length_count <= 16'(CHDR_HDR_BYTES);
          info_push    <= 1'b1;
        end else begin
          length_count <= length_count + beat_bytes;
        end
      end
    end
  end

  // Sideband and final length, taken on the last beat only
  always_ff @(posedge axis_data_clk) begin
    if (i_beat_accept && i_s_beat.tlast) begin
      info_entry.eob       <= i_s_sideband.eob;
      info_entry.eov       <= i_s_sideband.eov;
      info_entry.has_time  <= i_s_sideband.has_time;
      info_entry.timestamp <= i_s_sideband.timestamp;
      info_entry.length    <= length_count + beat_bytes;
    end
  end

  // --------------------
  // Info queue
  // --------------------

  // Occupancy including the entry still on its way in
  always_ff @(posedge axis_data_clk) begin
    if (axis_data_rst) begin
      info_count <= '0;
    end else begin
      info_count <= info_count + info_push - (o_info_valid && i_info_ready);
    end
  end

  assign info_pending = info_count + info_push;

  // Keep two slots spare
  // one for a last beat accepted now, one for a beat caught before gating lands
  assign o_info_space = fifo_ready && (int'(info_pending) + 2 <= 2 ** INFO_FIFO_LOG2);

  sync_fifo #(
    .WIDTH       ($bits(pkt_info_t)),
    .DEPTH_LOG2  (INFO_FIFO_LOG2)
  ) u_info_fifo (
    .axis_data_clk (axis_data_clk),
    .axis_data_rst (axis_data_rst),
    .i_data        (info_entry),
    .i_valid       (info_push),
    .o_ready       (fifo_ready),
    .o_data        (o_info),
    .o_valid       (o_info_valid),
    .i_ready_out   (i_info_ready)
  );

endmodule

`default_nettype wire

/* hdl/sync_fifo.sv */
`default_nettype none

module sync_fifo #(
  parameter int WIDTH      = 8,
  parameter int DEPTH_LOG2 = 4
) (
  input  wire logic             axis_data_clk,
  input  wire logic             axis_data_rst,
  // Write side
  input  wire logic [WIDTH-1:0] i_data,
  input  wire logic             i_valid,
  output logic                  o_ready,
  // Read side
  output logic      [WIDTH-1:0] o_data,
  output logic                  o_valid,
  input  wire logic             i_ready_out
);

  logic [WIDTH-1:0]      mem [2**DEPTH_LOG2];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2-1:0] wr_ptr_next;
  logic                  full;
  logic                  wr_en;
  logic                  rd_en;

  // Pointers equal means empty unless the full flag is set
  assign o_ready     = !full;
  assign o_valid     = full || (wr_ptr != rd_ptr);
  assign wr_en       = i_valid && o_ready;
  assign rd_en       = o_valid && i_ready_out;
  assign wr_ptr_next = wr_ptr + 1'b1;

  // Head entry shows without a read cycle
  assign o_data = mem[rd_ptr];

  always_ff @(posedge axis_data_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge axis_data_clk) begin
    if (axis_data_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      full   <= 1'b0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr_next;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      // Fill on a lone write that catches up, empty out on a lone read
      if (wr_en && !rd_en) begin
        full <= (wr_ptr_next == rd_ptr);
      end else if (rd_en && !wr_en) begin
        full <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_axis_data_to_chdr \
  -f axis_data_to_chdr.f -o tb_axis_data_to_chdr \
  || { echo "Build failed"; exit 1; }
./obj_dir/tb_axis_data_to_chdr > sim.log 2>&1
cat sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" \
  || { echo "FAIL"; exit 1; }
